// ==== hw/dcache_pkg.sv ====
/* sizes, access and request encodings, and the bus structs
   shared by the data cache, request queue and miss table */
package dcache_pkg;

    localparam int LSQ_SIZE     = 4;
    localparam int NUM_SETS     = 32;
    localparam int IDX_W        = 5;
    localparam int TAG_W        = 8;
    localparam int OFFSET_W     = 3;
    localparam int LINE_W       = 64;
    localparam int LINE_ADDR_W  = TAG_W + IDX_W;
    localparam int VICTIM_WAYS  = 2;
    localparam int QUEUE_DEPTH  = 8;
    localparam int QUEUE_PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int REQ_SLOTS    = 3;
    localparam int MISS_ENTRIES = 4;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_e;

    // MEM_NONE marks an idle request slot
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_WRITEBACK,
        MEM_WRITE,
        MEM_READ
    } mem_req_kind_e;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [IDX_W-1:0]    idx;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic              en;
        cache_addr_t       addr;
        logic [LINE_W-1:0] data;
        mem_size_e         size;
    } proc_wr_t;

    typedef struct packed {
        logic                en;
        cache_addr_t         addr;
        mem_size_e           size;
        logic [LSQ_SIZE-1:0] gnt;
    } proc_rd_t;

    typedef struct packed {
        mem_req_kind_e       kind;
        cache_addr_t         addr;
        logic [LINE_W-1:0]   data;
        mem_size_e           size;
        logic [LSQ_SIZE-1:0] gnt;
    } mem_req_t;

    // read responses always carry the whole line
    typedef struct packed {
        logic              valid;
        cache_addr_t       addr;
        logic [LINE_W-1:0] data;
    } mem_resp_t;

    typedef struct packed {
        logic              en;
        cache_addr_t       addr;
        logic [LINE_W-1:0] data;
    } fill_t;

endpackage

// ==== hw/dcache.sv ====
/* direct-mapped write-back data cache with a two-way victim buffer,
   no-write-allocate, hit/swap/fill/evict logic */
`timescale 1ns/1ps

module dcache
    import dcache_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  proc_wr_t            proc_wr,
    input  proc_rd_t            proc_rd,
    input  fill_t               fill,
    output logic [LINE_W-1:0]   rd_data,
    output logic [LSQ_SIZE-1:0] hit_feedback,
    output mem_req_t            wb_req,
    output mem_req_t            wr_req,
    output mem_req_t            rd_req
);

    typedef struct packed {
        logic [NUM_SETS-1:0][LINE_W-1:0]         data;
        logic [NUM_SETS-1:0][TAG_W-1:0]          tag;
        logic [NUM_SETS-1:0]                     valid;
        logic [NUM_SETS-1:0]                     dirty;
        logic [VICTIM_WAYS-1:0][LINE_ADDR_W-1:0] vtag;
        logic [VICTIM_WAYS-1:0][LINE_W-1:0]      vdata;
        logic [VICTIM_WAYS-1:0]                  vvalid;
        logic [VICTIM_WAYS-1:0]                  vdirty;
        logic                                    lru;
    } cache_state_t;

    cache_state_t st;
    cache_state_t st_wr;
    cache_state_t st_rd;
    cache_state_t st_fill;

    logic                   wr_hit;
    logic                   rd_hit;
    logic [VICTIM_WAYS-1:0] wr_vmatch;
    logic [VICTIM_WAYS-1:0] rd_vmatch;
    logic [VICTIM_WAYS-1:0] fill_vmatch;
    logic                   fill_in_main;
    logic                   fill_in_victim;
    logic                   evict_way;

    function automatic logic [LINE_W-1:0] size_mask(mem_size_e size);
        case (size)
            BYTE:    return {{(LINE_W-8){1'b0}}, 8'hff};
            HALF:    return {{(LINE_W-16){1'b0}}, 16'hffff};
            WORD:    return {{(LINE_W-32){1'b0}}, 32'hffff_ffff};
            default: return '1;
        endcase
    endfunction

    // store lanes selected by size and offset, keep the rest
    function automatic logic [LINE_W-1:0] merge(logic [LINE_W-1:0] line, logic [LINE_W-1:0] data,
                                                logic [OFFSET_W-1:0] offset, mem_size_e size);
        logic [LINE_W-1:0] lanes;
        lanes = size_mask(size) << {offset, 3'b000};
        return (line & ~lanes) | ((data << {offset, 3'b000}) & lanes);
    endfunction

    function automatic logic [LINE_W-1:0] extract(logic [LINE_W-1:0] line,
                                                  logic [OFFSET_W-1:0] offset, mem_size_e size);
        return (line >> {offset, 3'b000}) & size_mask(size);
    endfunction

    function automatic logic [VICTIM_WAYS-1:0] vmatch(cache_state_t s,
                                                      logic [LINE_ADDR_W-1:0] line);
        logic [VICTIM_WAYS-1:0] m;
        for (int w = 0; w < VICTIM_WAYS; w++) begin
            m[w] = s.vvalid[w] && s.vtag[w] == line;
        end
        return m;
    endfunction

    function automatic logic way_of(logic [VICTIM_WAYS-1:0] m);
        logic w;
        w = 1'b0;
        for (int i = 0; i < VICTIM_WAYS; i++) begin
            if (m[i]) w = i[0];
        end
        return w;
    endfunction

    // exchange victim way w with the main line at idx
    function automatic cache_state_t swap_in(cache_state_t s, logic w,
                                             logic [IDX_W-1:0] idx, logic [TAG_W-1:0] tag);
        cache_state_t r;
        r = s;
        r.vtag[w]   = {s.tag[idx], idx};
        r.vdata[w]  = s.data[idx];
        r.vvalid[w] = s.valid[idx];
        r.vdirty[w] = s.dirty[idx];
        r.tag[idx]   = tag;
        r.data[idx]  = s.vdata[w];
        r.valid[idx] = 1'b1;
        r.dirty[idx] = s.vdirty[w];
        r.lru = ~w;
        return r;
    endfunction

    assign wr_vmatch = vmatch(st, {proc_wr.addr.tag, proc_wr.addr.idx});
    assign wr_hit = st.valid[proc_wr.addr.idx] && st.tag[proc_wr.addr.idx] == proc_wr.addr.tag;

    assign rd_vmatch = vmatch(st_wr, {proc_rd.addr.tag, proc_rd.addr.idx});
    assign rd_hit = st_wr.valid[proc_rd.addr.idx]
                 && st_wr.tag[proc_rd.addr.idx] == proc_rd.addr.tag;

    assign fill_vmatch = vmatch(st_rd, {fill.addr.tag, fill.addr.idx});
    assign fill_in_main = st_rd.valid[fill.addr.idx] && st_rd.tag[fill.addr.idx] == fill.addr.tag;
    assign fill_in_victim = |fill_vmatch;
    // prefer a free way, otherwise the LRU one
    assign evict_way = (st_rd.vvalid[st_rd.lru] && !st_rd.vvalid[~st_rd.lru]) ? ~st_rd.lru
                                                                              : st_rd.lru;

    always_comb begin
        st_wr = st;
        wr_req = '0;
        if (proc_wr.en) begin
            if (wr_hit) begin
                st_wr.data[proc_wr.addr.idx] = merge(st.data[proc_wr.addr.idx], proc_wr.data,
                                                     proc_wr.addr.offset, proc_wr.size);
                st_wr.dirty[proc_wr.addr.idx] = 1'b1;
            end else if (|wr_vmatch) begin
                st_wr = swap_in(st, way_of(wr_vmatch), proc_wr.addr.idx, proc_wr.addr.tag);
                st_wr.data[proc_wr.addr.idx] = merge(st_wr.data[proc_wr.addr.idx], proc_wr.data,
                                                     proc_wr.addr.offset, proc_wr.size);
                st_wr.dirty[proc_wr.addr.idx] = 1'b1;
            end else begin
                // no allocate, straight to memory
                wr_req.kind = MEM_WRITE;
                wr_req.addr = proc_wr.addr;
                wr_req.data = proc_wr.data;
                wr_req.size = proc_wr.size;
            end
        end
    end

    always_comb begin
        st_rd = st_wr;
        rd_data = '0;
        hit_feedback = '0;
        rd_req = '0;
        if (proc_rd.en) begin
            if (rd_hit) begin
                rd_data = extract(st_wr.data[proc_rd.addr.idx], proc_rd.addr.offset, proc_rd.size);
                hit_feedback = proc_rd.gnt;
            end else if (|rd_vmatch) begin
                rd_data = extract(st_wr.vdata[way_of(rd_vmatch)], proc_rd.addr.offset,
                                  proc_rd.size);
                hit_feedback = proc_rd.gnt;
                st_rd = swap_in(st_wr, way_of(rd_vmatch), proc_rd.addr.idx, proc_rd.addr.tag);
            end else begin
                rd_req.kind = MEM_READ;
                rd_req.addr = proc_rd.addr;
                rd_req.size = proc_rd.size;
                rd_req.gnt  = proc_rd.gnt;
            end
        end
    end

    always_comb begin
        st_fill = st_rd;
        wb_req = '0;
        if (fill.en && !fill_in_main && !fill_in_victim) begin
            if (st_rd.valid[fill.addr.idx]) begin
                st_fill.vtag[evict_way]   = {st_rd.tag[fill.addr.idx], fill.addr.idx};
                st_fill.vdata[evict_way]  = st_rd.data[fill.addr.idx];
                st_fill.vvalid[evict_way] = 1'b1;
                st_fill.vdirty[evict_way] = st_rd.dirty[fill.addr.idx];
                st_fill.lru = ~evict_way;
                if (st_rd.vvalid[evict_way] && st_rd.vdirty[evict_way]) begin
                    wb_req.kind = MEM_WRITEBACK;
                    wb_req.addr = {st_rd.vtag[evict_way], {OFFSET_W{1'b0}}};
                    wb_req.data = st_rd.vdata[evict_way];
                    wb_req.size = DOUBLE;
                end
            end
            st_fill.data[fill.addr.idx]  = fill.data;
            st_fill.tag[fill.addr.idx]   = fill.addr.tag;
            st_fill.valid[fill.addr.idx] = 1'b1;
            st_fill.dirty[fill.addr.idx] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        st <= st_fill;
        if (reset) begin
            st.valid  <= '0;
            st.dirty  <= '0;
            st.vvalid <= '0;
            st.vdirty <= '0;
            st.lru    <= 1'b0;
        end
    end

    // a line lives in at most one victim way
    assert property (@(posedge clock) disable iff (reset)
        !(&st.vvalid && st.vtag[0] == st.vtag[1]));

    assert property (@(posedge clock) disable iff (reset)
        fill.en |-> !(fill_in_main && fill_in_victim));

endmodule

// ==== hw/mem_request_queue.sv ====
/* memory request FIFO, up to three pushes per cycle and one pop */
`timescale 1ns/1ps

module mem_request_queue
    import dcache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t wb_req,
    input  mem_req_t wr_req,
    input  mem_req_t rd_req,
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_ready
);

    mem_req_t buffer [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] head;
    logic [QUEUE_PTR_W-1:0] tail;
    logic [QUEUE_PTR_W:0]   count;

    mem_req_t [REQ_SLOTS-1:0]               slot_req;
    logic [REQ_SLOTS-1:0]                   slot_push;
    logic [REQ_SLOTS-1:0][QUEUE_PTR_W-1:0]  slot_ptr;
    logic [1:0]                             n_push;
    logic                                   pop;

    // slot 0 goes first
    assign slot_req = {rd_req, wr_req, wb_req};

    always_comb begin
        n_push = '0;
        for (int s = 0; s < REQ_SLOTS; s++) begin
            slot_push[s] = slot_req[s].kind != MEM_NONE;
            slot_ptr[s] = tail + QUEUE_PTR_W'(n_push);
            if (slot_push[s]) n_push = n_push + 2'd1;
        end
    end

    assign mem_req_valid = count != '0;
    assign mem_req = buffer[head];
    assign pop = mem_req_valid && mem_ready;

    always_ff @(posedge clock) begin
        for (int s = 0; s < REQ_SLOTS; s++) begin
            if (slot_push[s]) buffer[slot_ptr[s]] <= slot_req[s];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + QUEUE_PTR_W'(n_push);
            count <= count + (QUEUE_PTR_W+1)'(n_push) - (QUEUE_PTR_W+1)'(pop);
            if (pop) head <= head + 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        count <= QUEUE_DEPTH);

endmodule

// ==== hw/miss_status_table.sv ====
/* outstanding read misses with their load-queue grants,
   turns memory responses into cache fills */
`timescale 1ns/1ps

module miss_status_table
    import dcache_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  mem_req_t            rd_req,
    input  mem_resp_t           mem_resp,
    output fill_t               fill,
    output logic [LSQ_SIZE-1:0] fill_feedback
);

    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line;
        logic [LSQ_SIZE-1:0]    gnt;
    } miss_entry_t;

    miss_entry_t entry [MISS_ENTRIES];
    logic [MISS_ENTRIES-1:0] busy;

    logic [LINE_ADDR_W-1:0]  req_line;
    logic [LINE_ADDR_W-1:0]  resp_line;
    logic [MISS_ENTRIES-1:0] req_hit;
    logic [MISS_ENTRIES-1:0] resp_hit;
    logic [MISS_ENTRIES-1:0] free_vec;
    logic [MISS_ENTRIES-1:0] alloc_sel;
    logic                    req_valid;
    logic                    alloc;

    assign req_valid = rd_req.kind == MEM_READ;
    assign req_line  = {rd_req.addr.tag, rd_req.addr.idx};
    assign resp_line = {mem_resp.addr.tag, mem_resp.addr.idx};

    always_comb begin
        fill_feedback = '0;
        for (int i = 0; i < MISS_ENTRIES; i++) begin
            resp_hit[i] = mem_resp.valid && busy[i] && entry[i].line == resp_line;
            // an entry retiring this cycle takes no more grants
            req_hit[i] = busy[i] && !resp_hit[i] && entry[i].line == req_line;
            if (resp_hit[i]) fill_feedback = fill_feedback | entry[i].gnt;
        end
    end

    assign fill.en   = |resp_hit;
    assign fill.addr = mem_resp.addr;
    assign fill.data = mem_resp.data;

    // lowest free slot, freed entries reusable at once
    assign free_vec  = ~busy | resp_hit;
    assign alloc_sel = free_vec & ~(free_vec - 1'b1);
    assign alloc     = req_valid && !(|req_hit);

    always_ff @(posedge clock) begin
        for (int i = 0; i < MISS_ENTRIES; i++) begin
            if (req_valid && req_hit[i]) begin
                entry[i].gnt <= entry[i].gnt | rd_req.gnt;
            end else if (alloc && alloc_sel[i]) begin
                entry[i].line <= req_line;
                entry[i].gnt  <= rd_req.gnt;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~resp_hit) | (alloc ? alloc_sel : '0);
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        alloc |-> |free_vec);

endmodule

// ==== hw/dcache_subsystem.sv ====
/* data cache top: cache core, memory request queue and miss table */
`timescale 1ns/1ps

module dcache_subsystem
    import dcache_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  proc_wr_t            proc_wr,
    input  proc_rd_t            proc_rd,
    output logic [LINE_W-1:0]   rd_data,
    output logic [LSQ_SIZE-1:0] rd_feedback,
    output mem_req_t            mem_req,
    output logic                mem_req_valid,
    input  logic                mem_ready,
    input  mem_resp_t           mem_resp
);

    mem_req_t            wb_req;
    mem_req_t            wr_req;
    mem_req_t            rd_req;
    fill_t               fill;
    logic [LSQ_SIZE-1:0] hit_feedback;
    logic [LSQ_SIZE-1:0] fill_feedback;

    dcache u_dcache (
        .clock        (clock),
        .reset        (reset),
        .proc_wr      (proc_wr),
        .proc_rd      (proc_rd),
        .fill         (fill),
        .rd_data      (rd_data),
        .hit_feedback (hit_feedback),
        .wb_req       (wb_req),
        .wr_req       (wr_req),
        .rd_req       (rd_req)
    );

    mem_request_queue u_queue (
        .clock         (clock),
        .reset         (reset),
        .wb_req        (wb_req),
        .wr_req        (wr_req),
        .rd_req        (rd_req),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_ready     (mem_ready)
    );

    miss_status_table u_mst (
        .clock         (clock),
        .reset         (reset),
        .rd_req        (rd_req),
        .mem_resp      (mem_resp),
        .fill          (fill),
        .fill_feedback (fill_feedback)
    );

    // hits and fills both retire loads
    assign rd_feedback = hit_feedback | fill_feedback;

endmodule

// ==== bench/mem_responder.sv ====
/* behavioral memory: random-filled byte array, random ready,
   writes applied on transfer, reads answered 2 to 9 cycles later */
`timescale 1ns/1ps

module mem_responder
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  mem_req_t  mem_req,
    input  logic      mem_req_valid,
    input  logic      stall,
    output logic      mem_ready,
    output mem_resp_t mem_resp
);

    logic [7:0] mem [65536];
    mem_resp_t  pend_resp [$];
    int         pend_due [$];
    int         seed;
    int         now;

    initial begin
        logic [31:0] r;
        mem_ready <= 1'b0;
        mem_resp <= '0;
        seed = 19;
        for (int i = 0; i < 65536; i++) begin
            r = $random(seed);
            mem[i] = r[7:0];
        end
    end

    always @(posedge clock) begin
        mem_resp_t   r;
        logic [15:0] a;
        logic [31:0] pick;
        if (reset) begin
            now = 0;
            mem_ready <= 1'b0;
            mem_resp <= '0;
        end else begin
            now = now + 1;
            a = mem_req.addr;
            if (mem_req_valid && mem_ready) begin
                if (mem_req.kind == MEM_READ) begin
                    // whole line, snapshot at transfer
                    r.valid = 1'b1;
                    r.addr = mem_req.addr;
                    r.addr.offset = '0;
                    for (int b = 0; b < 8; b++) begin
                        r.data[b*8 +: 8] = mem[{a[15:3], 3'(b)}];
                    end
                    pick = $random(seed);
                    pend_resp.push_back(r);
                    pend_due.push_back(now + 2 + int'(pick[2:0]));
                end else begin
                    for (int b = 0; b < (1 << int'(mem_req.size)); b++) begin
                        mem[a + 16'(b)] = mem_req.data[b*8 +: 8];
                    end
                end
            end
            mem_resp <= '0;
            if (pend_due.size() > 0 && pend_due[0] <= now) begin
                mem_resp <= pend_resp.pop_front();
                void'(pend_due.pop_front());
            end
            pick = $random(seed);
            mem_ready <= !stall && pick[1:0] != 2'b00;
        end
    end

endmodule

// ==== bench/dcache_tb.sv ====
/* dcache subsystem testbench: scripted loads and stores, byte-image
   reference and memory request scoreboard, checked by assertions */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    logic                clock;
    logic                reset;
    proc_wr_t            proc_wr;
    proc_rd_t            proc_rd;
    logic [LINE_W-1:0]   rd_data;
    logic [LSQ_SIZE-1:0] rd_feedback;
    mem_req_t            mem_req;
    logic                mem_req_valid;
    logic                mem_ready;
    mem_resp_t           mem_resp;
    logic                stall;

    logic [7:0]          ref_mem [65536];
    mem_req_t            exp_reqs [32];
    int                  exp_head;
    int                  exp_tail;
    int                  tail_next;
    int                  seed;
    string               test_name;
    logic                chk_hit;
    logic                chk_miss;
    logic                chk_fill;
    logic [LINE_W-1:0]   exp_data;
    logic [LSQ_SIZE-1:0] exp_gnt;

    dcache_subsystem DUT (.*);

    mem_responder u_mem (.*);

    task automatic fail_run(string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic cache_addr_t address_of(int tag, int idx, int off);
        return '{tag: tag[TAG_W-1:0], idx: idx[IDX_W-1:0], offset: off[OFFSET_W-1:0]};
    endfunction

    function automatic logic [LINE_W-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // latest stored bytes, zero extended
    function automatic logic [LINE_W-1:0] ref_read(cache_addr_t addr, mem_size_e size);
        logic [LINE_W-1:0] v;
        v = '0;
        for (int b = 0; b < (1 << int'(size)); b++) begin
            v[b*8 +: 8] = ref_mem[16'(addr) + 16'(b)];
        end
        return v;
    endfunction

    function automatic void ref_write(cache_addr_t addr, mem_size_e size, logic [LINE_W-1:0] data);
        for (int b = 0; b < (1 << int'(size)); b++) begin
            ref_mem[16'(addr) + 16'(b)] = data[b*8 +: 8];
        end
    endfunction

    task automatic expect_req(mem_req_t req);
        exp_reqs[tail_next[4:0]] <= req;
        tail_next = tail_next + 1;
        exp_tail <= tail_next;
    endtask

    task automatic begin_test(string name);
        @(posedge clock);
        test_name = name;
    endtask

    task automatic store(cache_addr_t addr, mem_size_e size, logic [LINE_W-1:0] data, bit hit);
        @(posedge clock);
        proc_wr <= '{en: 1'b1, addr: addr, data: data, size: size};
        if (!hit) expect_req('{kind: MEM_WRITE, addr: addr, data: data, size: size, gnt: '0});
        ref_write(addr, size, data);
        @(posedge clock);
        proc_wr.en <= 1'b0;
    endtask

    task automatic drive_read(cache_addr_t addr, mem_size_e size, logic [LSQ_SIZE-1:0] gnt,
                              bit hit);
        @(posedge clock);
        proc_rd  <= '{en: 1'b1, addr: addr, size: size, gnt: gnt};
        exp_data <= ref_read(addr, size);
        exp_gnt  <= gnt;
        chk_hit  <= hit;
        chk_miss <= !hit;
        if (!hit) expect_req('{kind: MEM_READ, addr: addr, data: '0, size: size, gnt: gnt});
        @(posedge clock);
        proc_rd.en <= 1'b0;
        chk_hit  <= 1'b0;
        chk_miss <= 1'b0;
    endtask

    // miss, wait for the fill, then read again as a hit
    task automatic load_miss(cache_addr_t addr, mem_size_e size, logic [LSQ_SIZE-1:0] gnt,
                             bit wb, cache_addr_t wb_line);
        int n;
        drive_read(addr, size, gnt, 1'b0);
        if (wb) begin
            expect_req('{kind: MEM_WRITEBACK, addr: wb_line, data: ref_read(wb_line, DOUBLE),
                         size: DOUBLE, gnt: '0});
        end
        chk_fill <= 1'b1;
        n = 0;
        while (rd_feedback == '0) begin
            @(negedge clock);
            n++;
            if (n > 300) fail_run($sformatf("%s: no fill feedback after read miss", test_name));
        end
        drive_read(addr, size, gnt, 1'b1);
        chk_fill <= 1'b0;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            exp_head <= 0;
        end else if (mem_req_valid && mem_ready) begin
            exp_head <= exp_head + 1;
        end
    end

    assert property (@(posedge clock) disable iff (reset) chk_hit |-> rd_feedback == exp_gnt)
        else fail_run($sformatf("** Error [%s] hit feedback: expected %h, actual %h",
                                test_name, $sampled(exp_gnt), $sampled(rd_feedback)));

    assert property (@(posedge clock) disable iff (reset) chk_hit |-> rd_data == exp_data)
        else fail_run($sformatf("** Error [%s] load data: expected %h, actual %h",
                                test_name, $sampled(exp_data), $sampled(rd_data)));

    assert property (@(posedge clock) disable iff (reset) chk_miss |-> rd_feedback == '0)
        else fail_run($sformatf("** Error [%s] miss feedback: expected %h, actual %h",
                                test_name, '0, $sampled(rd_feedback)));

    assert property (@(posedge clock) disable iff (reset)
        chk_fill && rd_feedback != '0 |-> rd_feedback == exp_gnt)
        else fail_run($sformatf("** Error [%s] fill feedback: expected %h, actual %h",
                                test_name, $sampled(exp_gnt), $sampled(rd_feedback)));

    assert property (@(posedge clock) disable iff (reset)
        mem_req_valid && mem_ready |-> exp_head != exp_tail)
        else fail_run($sformatf("%s: memory request %h was not expected",
                                test_name, $sampled(mem_req)));

    assert property (@(posedge clock) disable iff (reset)
        mem_req_valid && mem_ready && exp_head != exp_tail |-> mem_req == exp_reqs[exp_head[4:0]])
        else fail_run($sformatf("** Error [%s] memory request: expected %h, actual %h",
                                test_name, $sampled(exp_reqs[exp_head[4:0]]), $sampled(mem_req)));

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        logic [31:0] r;
        reset <= 1'b1;
        proc_wr <= '0;
        proc_rd <= '0;
        stall <= 1'b0;
        chk_hit <= 1'b0;
        chk_miss <= 1'b0;
        chk_fill <= 1'b0;
        exp_data <= '0;
        exp_gnt <= '0;
        exp_tail <= 0;
        tail_next = 0;
        test_name = "reset";
        // same seed and order as the memory model
        seed = 19;
        for (int i = 0; i < 65536; i++) begin
            r = $random(seed);
            ref_mem[i] = r[7:0];
        end
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        begin_test("read_miss");
        load_miss(address_of(1, 3, 0), DOUBLE, 4'b0010, 1'b0, '0);

        begin_test("write_merge");
        store(address_of(1, 3, 0), DOUBLE, rand64(), 1'b1);
        store(address_of(1, 3, 5), BYTE, rand64(), 1'b1);
        store(address_of(1, 3, 2), HALF, rand64(), 1'b1);
        store(address_of(1, 3, 4), WORD, rand64(), 1'b1);
        drive_read(address_of(1, 3, 5), BYTE, 4'b0001, 1'b1);
        drive_read(address_of(1, 3, 2), HALF, 4'b0010, 1'b1);
        drive_read(address_of(1, 3, 4), WORD, 4'b0100, 1'b1);
        drive_read(address_of(1, 3, 0), DOUBLE, 4'b1000, 1'b1);

        begin_test("write_miss");
        store(address_of(2, 7, 4), WORD, rand64(), 1'b0);
        load_miss(address_of(2, 7, 4), WORD, 4'b0100, 1'b0, '0);

        // tags 3 and 4 end up in the victim ways of index 10
        begin_test("victim");
        for (int t = 3; t <= 5; t++) begin
            load_miss(address_of(t, 10, 0), DOUBLE, 4'b0001, 1'b0, '0);
        end
        drive_read(address_of(3, 10, 0), DOUBLE, 4'b0010, 1'b1);
        drive_read(address_of(4, 10, 0), DOUBLE, 4'b0100, 1'b1);

        // dirty tag 4 ages out, clean victims leave quietly
        begin_test("writeback");
        store(address_of(4, 10, 6), HALF, rand64(), 1'b1);
        load_miss(address_of(6, 10, 0), DOUBLE, 4'b0001, 1'b0, '0);
        load_miss(address_of(7, 10, 0), DOUBLE, 4'b0010, 1'b0, '0);
        load_miss(address_of(8, 10, 0), DOUBLE, 4'b0100, 1'b1, address_of(4, 10, 0));

        begin_test("backpressure");
        stall <= 1'b1;
        repeat (2) @(posedge clock);
        for (int i = 0; i < 5; i++) begin
            store(address_of(9, 12 + i, 0), DOUBLE, rand64(), 1'b0);
        end
        repeat (6) @(posedge clock);
        stall <= 1'b0;
        load_miss(address_of(9, 12, 0), DOUBLE, 4'b1000, 1'b0, '0);

        begin_test("drain");
        for (int n = 0; exp_head != exp_tail; n++) begin
            @(negedge clock);
            if (n > 500) fail_run("expected memory requests never reached the memory port");
        end
        repeat (20) @(posedge clock);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/dcache_pkg.sv
hw/dcache.sv
hw/mem_request_queue.sv
hw/miss_status_table.sv
hw/dcache_subsystem.sv
bench/mem_responder.sv
bench/dcache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the dcache testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f sim.f -o dcache_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
